// ==== source/lg_consts.svh ====
/*
  logic generator constants
  lane geometry, table size and register map
*/

`ifndef LG_CONSTS_SVH
`define LG_CONSTS_SVH

// lane geometry
`define LG_DN 2    // lane count
`define LG_DW 8    // pins per lane
`define LG_TAW 6   // table address width, 64 entries
`define LG_AW 10   // bus byte address width
`define LG_TN 4    // external trigger inputs

// register map, byte offsets
`define LG_ADDR_CTL 10'h000
`define LG_ADDR_TRG 10'h008
`define LG_ADDR_MODE 10'h010
`define LG_ADDR_BDR 10'h020
`define LG_ADDR_BDL 10'h024
`define LG_ADDR_BPL 10'h028
`define LG_ADDR_BPN 10'h02C
`define LG_ADDR_STS_BPL 10'h030
`define LG_ADDR_STS_BPN 10'h034
`define LG_ADDR_OE0 10'h040
`define LG_ADDR_OE1 10'h044
`define LG_ADDR_MSK 10'h048
`define LG_ADDR_VAL 10'h04C
`define LG_ADDR_TBL_BASE 10'h100  // entry i at base + 4*i
`define LG_TBL_MASK 10'h300       // window select bits for the table

`endif

// ==== source/lg_pkg.sv ====
/*
  logic generator shared types
  bus, configuration, status and stream structs
*/

`include "lg_consts.svh"

package lg_pkg;

  // register bus
  typedef struct packed {
    logic                wen;
    logic                ren;
    logic [`LG_AW-1:0]   addr;
    logic [31:0]         wdata;
  } reg_req_t;

  typedef struct packed {
    logic                ack;    // one cycle after request
    logic [31:0]         rdata;  // valid with ack
  } reg_rsp_t;

  // table write port, regs -> burst
  typedef struct packed {
    logic                       en;
    logic [`LG_TAW-1:0]         addr;
    logic [`LG_DN*`LG_DW-1:0]   data;
  } tbl_wr_t;

  typedef struct packed {
    logic        inf;  // endless periods
    logic [7:0]  bdr;  // sample repeats minus one
    logic [6:0]  bdl;  // samples per period
    logic [15:0] bpl;  // beats per period
    logic [15:0] bpn;  // period count
  } burst_cfg_t;

  typedef struct packed {
    logic        busy;
    logic [15:0] bpl;  // beat within period
    logic [15:0] bpn;  // periods done
  } burst_sts_t;

  // per pin drive settings, shared by all lanes
  typedef struct packed {
    logic [`LG_DW-1:0] oe0;
    logic [`LG_DW-1:0] oe1;
    logic [`LG_DW-1:0] msk;
    logic [`LG_DW-1:0] val;
  } drv_cfg_t;

  typedef logic [`LG_DW-1:0] smp_t;

  typedef struct packed {
    smp_t [`LG_DN-1:0] data;
    logic              per;   // first beat of a period
    logic              last;  // final beat of the burst
  } beat_t;

  typedef struct packed {
    logic [`LG_DW-1:0] o;  // output value
    logic [`LG_DW-1:0] e;  // output enable
  } pin_t;

endpackage

// ==== source/lg_regs.sv ====
/*
  logic generator register bank
  bus decode, config and status read-back, table writes, triggers
*/

`timescale 1ns/1ps

`include "lg_consts.svh"

module lg_regs (
  input  logic                     bus,
  input  logic                     rst_n,
  input  lg_pkg::reg_req_t         req,
  output lg_pkg::reg_rsp_t         rsp,
  input  logic [`LG_TN-1:0]        trg,
  input  lg_pkg::burst_sts_t       sts,
  output lg_pkg::tbl_wr_t          tbl_wr,
  output lg_pkg::burst_cfg_t       bcfg,
  output lg_pkg::drv_cfg_t         dcfg,
  output logic                     start
);

  logic [`LG_TN-1:0] cfg_trg;  // external trigger mask
  logic [`LG_TN-1:0] trg_q;    // previous trg, edge detect
  logic              swt_q;    // software trigger pulse
  logic              ext_trg;
  logic              tbl_sel;
  logic [31:0]       rd_mux;

  assign tbl_sel = (req.addr & `LG_TBL_MASK) == `LG_ADDR_TBL_BASE;

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      rsp.ack <= 1'b0;
    end else begin
      rsp.ack <= req.wen | req.ren;  // single cycle pulse
    end
  end

  ////////////////////////////////////////
  // configuration writes
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      cfg_trg <= '0;
      bcfg    <= '0;
      dcfg    <= '0;
    end else if (req.wen) begin
      case (req.addr)
        `LG_ADDR_TRG:  cfg_trg  <= req.wdata[`LG_TN-1:0];
        `LG_ADDR_MODE: bcfg.inf <= req.wdata[1];
        `LG_ADDR_BDR:  bcfg.bdr <= req.wdata[7:0];
        `LG_ADDR_BDL:  bcfg.bdl <= req.wdata[6:0];
        `LG_ADDR_BPL:  bcfg.bpl <= req.wdata[15:0];
        `LG_ADDR_BPN:  bcfg.bpn <= req.wdata[15:0];
        `LG_ADDR_OE0:  dcfg.oe0 <= req.wdata[`LG_DW-1:0];
        `LG_ADDR_OE1:  dcfg.oe1 <= req.wdata[`LG_DW-1:0];
        `LG_ADDR_MSK:  dcfg.msk <= req.wdata[`LG_DW-1:0];
        `LG_ADDR_VAL:  dcfg.val <= req.wdata[`LG_DW-1:0];
        default: ;  // ctl and table handled below
      endcase
    end
  end

  // table write port, one cycle after the request
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      tbl_wr.en <= 1'b0;
    end else begin
      tbl_wr.en <= req.wen & tbl_sel;
    end
  end

  always_ff @(posedge bus) begin
    if (req.wen && tbl_sel) begin
      tbl_wr.addr <= req.addr[`LG_TAW+1:2];  // word index
      tbl_wr.data <= req.wdata[`LG_DN*`LG_DW-1:0];
    end
  end

  ////////////////////////////////////////
  // read-back
  ////////////////////////////////////////

  always_comb begin
    case (req.addr)
      `LG_ADDR_CTL:     rd_mux = {31'd0, sts.busy};
      `LG_ADDR_TRG:     rd_mux = {{(32-`LG_TN){1'b0}}, cfg_trg};
      `LG_ADDR_MODE:    rd_mux = {30'd0, bcfg.inf, 1'b0};
      `LG_ADDR_BDR:     rd_mux = {24'd0, bcfg.bdr};
      `LG_ADDR_BDL:     rd_mux = {25'd0, bcfg.bdl};
      `LG_ADDR_BPL:     rd_mux = {16'd0, bcfg.bpl};
      `LG_ADDR_BPN:     rd_mux = {16'd0, bcfg.bpn};
      `LG_ADDR_STS_BPL: rd_mux = {16'd0, sts.bpl};
      `LG_ADDR_STS_BPN: rd_mux = {16'd0, sts.bpn};
      `LG_ADDR_OE0:     rd_mux = {{(32-`LG_DW){1'b0}}, dcfg.oe0};
      `LG_ADDR_OE1:     rd_mux = {{(32-`LG_DW){1'b0}}, dcfg.oe1};
      `LG_ADDR_MSK:     rd_mux = {{(32-`LG_DW){1'b0}}, dcfg.msk};
      `LG_ADDR_VAL:     rd_mux = {{(32-`LG_DW){1'b0}}, dcfg.val};
      default:          rd_mux = 32'd0;  // unmapped, table included
    endcase
  end

  always_ff @(posedge bus) begin
    if (req.ren) rsp.rdata <= rd_mux;  // lines up with ack
  end

  ////////////////////////////////////////
  // triggers
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      swt_q <= 1'b0;
      trg_q <= '0;
    end else begin
      swt_q <= req.wen & (req.addr == `LG_ADDR_CTL) & req.wdata[0];
      trg_q <= trg;
    end
  end

  assign ext_trg = |(trg & ~trg_q & cfg_trg);  // masked rising edges

  // dropped while a burst runs
  assign start = (swt_q | ext_trg) & ~sts.busy;

endmodule

// ==== source/lg_burst.sv ====
/*
  logic generator burst sequencer
  pattern table plus repeat, sample, beat and period counters
*/

`timescale 1ns/1ps

`include "lg_consts.svh"

module lg_burst (
  input  logic                 bus,
  input  logic                 rst_n,
  input  lg_pkg::tbl_wr_t      tbl_wr,
  input  lg_pkg::burst_cfg_t   cfg,
  input  logic                 start,
  output lg_pkg::burst_sts_t   sts,
  output lg_pkg::beat_t        beat,
  output logic                 valid,
  input  logic                 ready
);

  logic [`LG_DN*`LG_DW-1:0] tbl [2**`LG_TAW];  // pattern table
  logic [`LG_DN*`LG_DW-1:0] rd;                // sample of current beat
  logic [`LG_TAW-1:0]       rd_addr;

  logic        busy;
  logic        ld;       // first table read of a burst
  logic        xfer;
  logic [7:0]  rep;      // repeat count of current sample
  logic [6:0]  idx;      // sample index, stops at bdl
  logic [15:0] bpl_cnt;  // beat within period
  logic [15:0] bpn_cnt;  // period number

  logic        per_end;
  logic        rep_end;
  logic        pad;
  logic        last_beat;
  logic [7:0]  nxt_rep;
  logic [6:0]  nxt_idx;
  logic [15:0] nxt_bpl;
  logic [15:0] nxt_bpn;

  assign xfer = valid & ready;

  ////////////////////////////////////////
  // counter next state
  ////////////////////////////////////////

  always_comb begin
    per_end = (bpl_cnt == cfg.bpl - 16'd1);
    rep_end = (rep == cfg.bdr);
    pad     = (idx >= cfg.bdl);  // idle part of the period
    nxt_rep = rep;
    nxt_idx = idx;
    nxt_bpl = bpl_cnt + 16'd1;
    nxt_bpn = bpn_cnt;
    if (per_end) begin
      // wrap into next period
      nxt_rep = 8'd0;
      nxt_idx = 7'd0;
      nxt_bpl = 16'd0;
      nxt_bpn = bpn_cnt + 16'd1;
    end else if (!pad) begin
      if (rep_end) begin
        nxt_rep = 8'd0;
        nxt_idx = idx + 7'd1;
      end else begin
        nxt_rep = rep + 8'd1;
      end
    end
  end

  assign last_beat = per_end & ~cfg.inf & (bpn_cnt == cfg.bpn - 16'd1);

  ////////////////////////////////////////
  // sequencer state
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      ld      <= 1'b0;
      valid   <= 1'b0;
      rep     <= '0;
      idx     <= '0;
      bpl_cnt <= '0;
      bpn_cnt <= '0;
    end else begin
      ld <= start & ~busy;
      if (start && !busy) begin
        busy    <= 1'b1;
        rep     <= '0;
        idx     <= '0;
        bpl_cnt <= '0;
        bpn_cnt <= '0;
      end else if (xfer) begin
        // counters only move on a transfer
        rep     <= nxt_rep;
        idx     <= nxt_idx;
        bpl_cnt <= nxt_bpl;
        bpn_cnt <= nxt_bpn;
        if (last_beat) begin
          busy  <= 1'b0;
          valid <= 1'b0;
        end
      end
      if (ld) valid <= 1'b1;  // first beat after the table read
    end
  end

  ////////////////////////////////////////
  // table
  ////////////////////////////////////////

  // padding wraps the address, data is zeroed anyway
  assign rd_addr = ld ? '0 : nxt_idx[`LG_TAW-1:0];

  always_ff @(posedge bus) begin
    if (tbl_wr.en) tbl[tbl_wr.addr] <= tbl_wr.data;
    if (ld || xfer) rd <= tbl[rd_addr];  // prefetch next beat
  end

  // beat built from held state, steady while stalled
  assign beat.data = pad ? '0 : rd;
  assign beat.per  = (bpl_cnt == 16'd0);
  assign beat.last = last_beat;

  assign sts.busy = busy;
  assign sts.bpl  = bpl_cnt;
  assign sts.bpn  = bpn_cnt;

endmodule

// ==== source/lg_lane.sv ====
/*
  logic generator lane drive stage
  polarity, mask and per pin output enable
*/

`timescale 1ns/1ps

module lg_lane (
  input  lg_pkg::drv_cfg_t   cfg,
  input  lg_pkg::smp_t       smp,
  output lg_pkg::pin_t       pin
);

  lg_pkg::smp_t masked;  // sample with masked pins forced low
  lg_pkg::smp_t level;   // driven pin level

  assign masked = smp & ~cfg.msk;

  // val flips polarity so masked pins show val
  assign level = cfg.val ^ masked;
  assign pin.o = level;

  // enable picked per pin by the driven level
  assign pin.e = (cfg.oe1 & level) | (cfg.oe0 & ~level);

endmodule

// ==== source/lg_merge.sv ====
/*
  logic generator output stage
  one-entry register for the pin stream, tro and irq pulses
*/

`timescale 1ns/1ps

`include "lg_consts.svh"

module lg_merge (
  input  logic                           bus,
  input  logic                           rst_n,
  input  lg_pkg::pin_t [`LG_DN-1:0]      pins_in,
  input  logic                           per_in,
  input  logic                           last_in,
  input  logic                           valid_in,
  output logic                           ready_out,
  output lg_pkg::pin_t [`LG_DN-1:0]      pins,
  output logic                           per,
  output logic                           last,
  output logic                           valid,
  input  logic                           ready,
  output logic                           tro,
  output logic                           irq
);

  logic xfer;  // output beat taken downstream

  assign xfer = valid & ready;

  // free slot or slot draining this cycle
  assign ready_out = ~valid | ready;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (ready_out) begin
      valid <= valid_in;
    end
  end

  // payload only loads with a new beat
  always_ff @(posedge bus) begin
    if (ready_out && valid_in) begin
      pins <= pins_in;
      per  <= per_in;
      last <= last_in;
    end
  end

  assign tro = xfer & per;   // period start
  assign irq = xfer & last;  // burst done

endmodule

// ==== source/lg_top.sv ====
/*
  logic generator top
  register bank, burst sequencer, lane stages and output stage
*/

`timescale 1ns/1ps

`include "lg_consts.svh"

module lg_top (
  input  logic                           bus,
  input  logic                           rst_n,
  input  lg_pkg::reg_req_t               req,
  output lg_pkg::reg_rsp_t               rsp,
  input  logic [`LG_TN-1:0]              trg,
  output lg_pkg::pin_t [`LG_DN-1:0]      pins,
  output logic                           per,
  output logic                           last,
  output logic                           valid,
  input  logic                           ready,
  output logic                           tro,
  output logic                           irq
);

  lg_pkg::tbl_wr_t              tbl_wr;
  lg_pkg::burst_cfg_t           bcfg;
  lg_pkg::drv_cfg_t             dcfg;
  lg_pkg::burst_sts_t           sts;
  lg_pkg::beat_t                beat;
  lg_pkg::pin_t [`LG_DN-1:0]    lane_pins;
  logic                         start;
  logic                         beat_valid;
  logic                         beat_ready;

  lg_regs lg_regs_i (.bus(bus), .rst_n(rst_n), .req(req), .rsp(rsp), .trg(trg),
    .sts(sts), .tbl_wr(tbl_wr), .bcfg(bcfg), .dcfg(dcfg), .start(start));

  lg_burst lg_burst_i (.bus(bus), .rst_n(rst_n), .tbl_wr(tbl_wr), .cfg(bcfg),
    .start(start), .sts(sts), .beat(beat), .valid(beat_valid), .ready(beat_ready));

  // one drive stage per lane
  for (genvar i = 0; i < `LG_DN; i++) begin : for_dn
    lg_lane lg_lane_i (.cfg(dcfg), .smp(beat.data[i]), .pin(lane_pins[i]));
  end

  lg_merge lg_merge_i (.bus(bus), .rst_n(rst_n), .pins_in(lane_pins),
    .per_in(beat.per), .last_in(beat.last), .valid_in(beat_valid),
    .ready_out(beat_ready), .pins(pins), .per(per), .last(last), .valid(valid),
    .ready(ready), .tro(tro), .irq(irq));

endmodule

// ==== sim/lg_assert.sv ====
/*
  logic generator protocol assertions
  bus ack timing, output stall stability, tro and irq on transfers
*/

`timescale 1ns/1ps

`include "lg_consts.svh"

module lg_assert (
  input  logic                      bus,
  input  logic                      rst_n,
  input  lg_pkg::reg_req_t          req,
  input  lg_pkg::reg_rsp_t          rsp,
  input  lg_pkg::pin_t [`LG_DN-1:0] pins,
  input  logic                      per,
  input  logic                      last,
  input  logic                      valid,
  input  logic                      ready,
  input  logic                      tro,
  input  logic                      irq
);

  // ack exactly one cycle after each request
  a_ack: assert property (@(posedge bus) disable iff (!rst_n)
    (req.wen || req.ren) |=> rsp.ack) else $error("ack missing after request");
  a_no_ack: assert property (@(posedge bus) disable iff (!rst_n)
    !(req.wen || req.ren) |=> !rsp.ack) else $error("ack without request");

  // stalled beat holds
  a_stall: assert property (@(posedge bus) disable iff (!rst_n)
    (valid && !ready) |=> (valid && $stable(pins) && $stable(per) && $stable(last)))
    else $error("output beat changed while stalled");

  a_tro: assert property (@(posedge bus) disable iff (!rst_n)
    tro |-> (valid && ready && per)) else $error("tro outside a per transfer");
  a_irq: assert property (@(posedge bus) disable iff (!rst_n)
    irq |-> (valid && ready && last)) else $error("irq outside a last transfer");

endmodule

bind lg_top lg_assert lg_assert_i (.bus(bus), .rst_n(rst_n), .req(req), .rsp(rsp),
  .pins(pins), .per(per), .last(last), .valid(valid), .ready(ready), .tro(tro), .irq(irq));

// ==== sim/lg_tb.sv ====
/*
  logic generator testbench
  golden file stimulus, random back-pressure, beat and register checks
*/

`timescale 1ns/1ps

`include "lg_consts.svh"

module lg_tb;

  logic                      bus = 1'b0;
  logic                      rst_n;
  lg_pkg::reg_req_t          req;
  lg_pkg::reg_rsp_t          rsp;
  logic [`LG_TN-1:0]         trg;
  lg_pkg::pin_t [`LG_DN-1:0] pins;
  logic                      per;
  logic                      last;
  logic                      valid;
  logic                      ready = 1'b0;
  logic                      tro;
  logic                      irq;

  logic [15:0] lfsr_q = 16'd92;  // back-pressure source
  logic [33:0] exp_q [$];        // {o0, e0, o1, e1, per, last}
  logic [33:0] exp_beat;
  logic [33:0] got_beat;
  integer      nbeat = 0;

  lg_top lg_top_i (.bus(bus), .rst_n(rst_n), .req(req), .rsp(rsp), .trg(trg),
    .pins(pins), .per(per), .last(last), .valid(valid), .ready(ready),
    .tro(tro), .irq(irq));

  always #2 bus = ~bus;  // 4 ns period

  // fibonacci taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  always @(posedge bus) begin
    #0.5;
    ready = lfsr_q[15];  // next lfsr bit each cycle
    lfsr_q = lfsr_next(lfsr_q);
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // bus, trigger and drain helpers
  ////////////////////////////////////////

  task automatic bus_access(input logic wr, input logic [`LG_AW-1:0] a,
                            input logic [31:0] d, output logic [31:0] rd);
    integer n;
    n = 0;
    req.wen = wr;
    req.ren = ~wr;
    req.addr = a;
    req.wdata = d;
    @(posedge bus);
    #0.5;
    req = '0;  // single request cycle
    while (!rsp.ack && n < 20) begin
      n++;
      @(posedge bus);
      #0.5;
    end
    if (!rsp.ack) stop_on_error("timeout waiting for bus ack");
    rd = rsp.rdata;
  endtask

  task automatic pulse_trigger(input logic [1:0] n);
    trg[n] = 1'b1;
    @(posedge bus);
    #0.5;
    trg[n] = 1'b0;
  endtask

  // all expected beats seen at the output
  task automatic wait_drain();
    integer n;
    n = 0;
    while (exp_q.size() != 0 && n < 1000) begin
      n++;
      @(posedge bus);
      #0.5;
    end
    if (exp_q.size() != 0) stop_on_error("timeout waiting for expected output beats");
  endtask

  ////////////////////////////////////////
  // output stream checker
  ////////////////////////////////////////

  always @(posedge bus) begin
    if (rst_n) begin
      if (valid && ready) begin
        assert (exp_q.size() != 0) else stop_on_error("output beat arrived with none expected");
        exp_beat = exp_q.pop_front();
        got_beat = {pins[0].o, pins[0].e, pins[1].o, pins[1].e, per, last};
        assert (got_beat == exp_beat) else stop_on_error($sformatf(
          "** Error at %0t: beat %0d got %h expected %h", $time, nbeat, got_beat, exp_beat));
        assert (tro == exp_beat[1] && irq == exp_beat[0]) else stop_on_error($sformatf(
          "** Error at %0t: beat %0d tro %b irq %b", $time, nbeat, tro, irq));
        nbeat++;
      end else begin
        assert (!tro && !irq) else stop_on_error("tro or irq pulsed without a transfer");
      end
    end
  end

  ////////////////////////////////////////
  // golden file sequencer
  ////////////////////////////////////////

  initial begin
    integer      fd;
    integer      code;
    integer      c;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] rd;
    logic [7:0]  o0;
    logic [7:0]  e0;
    logic [7:0]  o1;
    logic [7:0]  e1;
    logic        bp;
    logic        bl;
    rst_n = 1'b0;
    req = '0;
    trg = '0;
    fd = $fopen("sim/lg_golden.txt", "r");
    if (fd == 0) stop_on_error("cannot open sim/lg_golden.txt");
    repeat (8) @(posedge bus);
    #0.5;
    rst_n = 1'b1;
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        c = $fgetc(fd);  // skip comment line
        while (c != 10 && c != -1) c = $fgetc(fd);
      end else if (op == "B") begin
        code = $fscanf(fd, "%h %h %h %h %h %h", o0, e0, o1, e1, bp, bl);
        if (code != 6) stop_on_error("malformed beat line in golden file");
        exp_q.push_back({o0, e0, o1, e1, bp, bl});
      end else begin
        wait_drain();  // earlier burst finished first
        if (op == "W" || op == "R") begin
          code = $fscanf(fd, "%h %h", a, d);
          if (code != 2) stop_on_error("malformed bus line in golden file");
          bus_access(op == "W", a[`LG_AW-1:0], d, rd);
          if (op == "R") assert (rd == d) else stop_on_error($sformatf(
            "** Error at %0t: read %h got %h expected %h", $time, a, rd, d));
        end else if (op == "T") begin
          bus_access(1'b1, `LG_ADDR_CTL, 32'd1, rd);  // software trigger
        end else if (op == "X") begin
          code = $fscanf(fd, "%h", a);
          if (code != 1) stop_on_error("malformed trigger line in golden file");
          pulse_trigger(a[1:0]);
        end else begin
          stop_on_error("unknown command in golden file");
        end
      end
    end
    wait_drain();
    $fclose(fd);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== sim/lg_golden.txt ====
# W addr data / R addr expected / T / X trg_bit / all hex
# B o0 e0 o1 e1 per last, next expected output beat
W 100 12A5
W 104 3C0F
W 020 1
W 024 2
W 028 5
W 02C 2
R 020 1
R 024 2
R 028 5
R 02C 2
T
B A5 00 12 00 1 0
B A5 00 12 00 0 0
B 0F 00 3C 00 0 0
B 0F 00 3C 00 0 0
B 00 00 00 00 0 0
B A5 00 12 00 1 0
B A5 00 12 00 0 0
B 0F 00 3C 00 0 0
B 0F 00 3C 00 0 0
B 00 00 00 00 0 1
W 02C 1
W 040 0F
W 044 F0
W 048 33
W 04C 5A
R 048 33
T
B DE D1 5A 55 1 0
B DE D1 5A 55 0 0
B 56 59 56 59 0 0
B 56 59 56 59 0 0
B 5A 55 5A 55 0 1
W 028 1
W 008 4
X 1
R 000 0
X 2
R 000 1
B DE D1 5A 55 1 1
R 034 1

// ==== flist.f ====
+incdir+source
source/lg_pkg.sv
source/lg_regs.sv
source/lg_burst.sv
source/lg_lane.sv
source/lg_merge.sv
source/lg_top.sv
sim/lg_assert.sv
sim/lg_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the logic generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f --top-module lg_tb -o lg_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/lg_sim; then
  echo "simulation failed"
  exit 1
fi

exit 0
